// File: hdl/usb_line_pkg.sv
/*
  Line sample types for the USB link-state tracker.
  Raw pin samples enter the line conditioner, filtered levels leave it.
*/

package usb_line_pkg;

  ////////////////////////////////////////////////////////////
  // Raw pins
  ////////////////////////////////////////////////////////////

  // Pins as sampled this cycle, already synchronous to clk_48mhz
  typedef struct packed {
    logic sense;  // VBUS power sense
    logic dp;     // D+ receive level
    logic dn;     // D- receive level
    logic oe;     // Device is driving the bus
  } line_sample_t;

  ////////////////////////////////////////////////////////////
  // Conditioned levels
  ////////////////////////////////////////////////////////////

  // Glitch-filtered levels seen by the event detector and FSM
  typedef struct packed {
    logic powered;  // Stable power sense
    logic se0;      // Stable single-ended zero
  } line_cond_t;

endpackage

// File: hdl/usb_link_pkg.sv
/*
  Link-level types shared by the bus event detector, the link FSM,
  the SOF monitor and the top level.
*/

package usb_link_pkg;

  // All microsecond timers share this width
  typedef logic [11:0] us_count_t;

  ////////////////////////////////////////////////////////////
  // Link state
  ////////////////////////////////////////////////////////////

  // Encoding matches the status register field of the device
  typedef enum logic [2:0] {
    link_disconnected      = 3'd0,
    link_powered           = 3'd1,
    link_powered_suspended = 3'd2,
    link_active            = 3'd3,
    link_suspended         = 3'd4,
    link_active_no_sof     = 3'd5,
    link_resuming          = 3'd6
  } link_state_e;

  // Timed bus events, pulses and levels
  typedef struct packed {
    logic bus_reset;     // Pulse, end of a qualified reset
    logic in_reset;      // Level, reset qualified and SE0 still present
    logic bus_inactive;  // Pulse, inactivity timeout expired
    logic bus_active;    // Level, receiver not idle
  } bus_events_t;

  // Status levels for software plus the raw state
  typedef struct packed {
    logic        disconnect;
    logic        powered;
    logic        reset;
    logic        active;
    logic        suspend;
    link_state_e state;
  } link_status_t;

endpackage

// File: hdl/usb_us_tick.sv
/*
  Microsecond time base. Divides the 48 MHz clock down to a single-cycle
  pulse once every ClksPerUs clocks; all timeouts count these pulses.
*/

`timescale 1ns/1ps

module usb_us_tick #(
  parameter int unsigned ClksPerUs = 48
) (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  output logic us_tick_o
);

  localparam int unsigned CntW = $clog2(ClksPerUs);

  logic [CntW-1:0] div_q;
  logic            wrap;

  // Last clock of the microsecond
  assign wrap = (div_q == CntW'(ClksPerUs - 1));

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q     <= '0;
      us_tick_o <= 1'b0;
    end else begin
      // Registered pulse, first one ClksPerUs cycles out of reset
      div_q     <= wrap ? '0 : div_q + 1'b1;
      us_tick_o <= wrap;
    end
  end

endmodule

// File: hdl/usb_line_cond.sv
/*
  Line conditioner. Forms raw SE0 from the receive pins and filters SE0
  and power sense; a filtered level only moves once the raw input has held
  the new value for FilterCycles consecutive clocks.
*/

`timescale 1ns/1ps

module usb_line_cond #(
  parameter int unsigned FilterCycles = 6
) (
  input  logic                      clk_48mhz_i,
  input  logic                      rst_ni,
  input  usb_line_pkg::line_sample_t line_i,
  output usb_line_pkg::line_cond_t   cond_o
);

  localparam int unsigned CntW    = $clog2(FilterCycles + 1);
  localparam int unsigned NumCh   = 2;
  localparam int unsigned ChSe0   = 0;
  localparam int unsigned ChSense = 1;

  logic             se0_raw;
  logic [NumCh-1:0] raw;
  logic [NumCh-1:0] held_q;
  logic [CntW-1:0]  cnt_q [NumCh];

  // SE0 only counts while the device itself is not driving
  assign se0_raw = !line_i.dp && !line_i.dn && !line_i.oe;

  assign raw[ChSe0]   = se0_raw;
  assign raw[ChSense] = line_i.sense;

  ////////////////////////////////////////////////////////////
  // Per-channel stability filters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= '0;
      for (int ch = 0; ch < NumCh; ch++) begin
        cnt_q[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < NumCh; ch++) begin
        if (raw[ch] == held_q[ch]) begin
          // Input agrees with output, nothing pending
          cnt_q[ch] <= '0;
        end else if (cnt_q[ch] == CntW'(FilterCycles - 1)) begin
          held_q[ch] <= raw[ch];
          cnt_q[ch]  <= '0;
        end else begin
          cnt_q[ch] <= cnt_q[ch] + 1'b1;
        end
      end
    end
  end

  assign cond_o.se0     = held_q[ChSe0];
  assign cond_o.powered = held_q[ChSense];

endmodule

// File: hdl/usb_bus_events.sv
/*
  Bus event detector. Times filtered SE0 to qualify a bus reset and times
  bus idle to flag inactivity (suspend). Both timers count microsecond
  ticks; the link state comes back from the FSM to gate idle monitoring.
*/

`timescale 1ns/1ps

module usb_bus_events #(
  parameter int unsigned ResetTimeoutUs   = 3,
  parameter int unsigned SuspendTimeoutUs = 3000
) (
  input  logic                       clk_48mhz_i,
  input  logic                       rst_ni,
  input  logic                       us_tick_i,
  input  usb_line_pkg::line_cond_t   cond_i,
  input  logic                       rx_idle_det_i,
  input  usb_link_pkg::link_state_e  link_state_i,
  output usb_link_pkg::bus_events_t  events_o
);

  typedef enum logic [1:0] {
    rst_none,
    rst_counting,
    rst_pending
  } rst_state_e;

  typedef enum logic [1:0] {
    inac_active,
    inac_counting,
    inac_pending
  } inac_state_e;

  rst_state_e              rst_state_d, rst_state_q;
  usb_link_pkg::us_count_t rst_timer_d, rst_timer_q;
  inac_state_e             inac_state_d, inac_state_q;
  usb_link_pkg::us_count_t inac_timer_d, inac_timer_q;

  logic bus_active;
  logic monitor_inac;
  logic ev_reset;
  logic in_reset;
  logic ev_inactive;

  assign bus_active = !rx_idle_det_i;

  // Idle only matters once powered and in a state that can suspend
  assign monitor_inac = cond_i.powered &&
                        (link_state_i inside {usb_link_pkg::link_powered,
                                              usb_link_pkg::link_active,
                                              usb_link_pkg::link_active_no_sof});

  ////////////////////////////////////////////////////////////
  // Reset detection
  ////////////////////////////////////////////////////////////

  always_comb begin
    rst_state_d = rst_state_q;
    rst_timer_d = rst_timer_q;
    ev_reset    = 1'b0;
    in_reset    = 1'b0;
    unique case (rst_state_q)
      rst_none: begin
        // Rise of SE0 starts the timer
        if (cond_i.se0) begin
          rst_state_d = rst_counting;
          rst_timer_d = '0;
        end
      end
      rst_counting: begin
        if (!cond_i.se0) begin
          // Too short for a reset, e.g. end of packet
          rst_state_d = rst_none;
        end else if (us_tick_i) begin
          if (rst_timer_q == usb_link_pkg::us_count_t'(ResetTimeoutUs)) begin
            rst_state_d = rst_pending;
          end else begin
            rst_timer_d = rst_timer_q + 1'b1;
          end
        end
      end
      rst_pending: begin
        // Qualified reset, event fires as SE0 goes away
        in_reset = 1'b1;
        if (!cond_i.se0) begin
          rst_state_d = rst_none;
          ev_reset    = 1'b1;
        end
      end
      default: rst_state_d = rst_none;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Inactivity detection
  ////////////////////////////////////////////////////////////

  always_comb begin
    inac_state_d = inac_state_q;
    inac_timer_d = inac_timer_q;
    ev_inactive  = 1'b0;
    unique case (inac_state_q)
      inac_active: begin
        inac_timer_d = '0;
        if (!bus_active && monitor_inac) begin
          inac_state_d = inac_counting;
        end
      end
      inac_counting: begin
        if (bus_active || !monitor_inac) begin
          inac_state_d = inac_active;
        end else if (us_tick_i) begin
          if (inac_timer_q == usb_link_pkg::us_count_t'(SuspendTimeoutUs)) begin
            inac_state_d = inac_pending;
            ev_inactive  = 1'b1;
          end else begin
            inac_timer_d = inac_timer_q + 1'b1;
          end
        end
      end
      inac_pending: begin
        // Event already sent, wait for activity to rearm
        if (bus_active || !monitor_inac) begin
          inac_state_d = inac_active;
        end
      end
      default: inac_state_d = inac_active;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_state_q  <= rst_none;
      rst_timer_q  <= '0;
      inac_state_q <= inac_active;
      inac_timer_q <= '0;
    end else begin
      rst_state_q  <= rst_state_d;
      rst_timer_q  <= rst_timer_d;
      inac_state_q <= inac_state_d;
      inac_timer_q <= inac_timer_d;
    end
  end

  assign events_o.bus_reset    = ev_reset;
  assign events_o.in_reset     = in_reset;
  assign events_o.bus_inactive = ev_inactive;
  assign events_o.bus_active   = bus_active;

endmodule

// File: hdl/usb_link_fsm.sv
/*
  Link state machine. Tracks attach, reset, frames, suspend and resume
  from the bus events and receiver flags, and decodes the status levels.
  link_resume_o pulses on the transitions that end a suspend.
*/

`timescale 1ns/1ps

module usb_link_fsm (
  input  logic                       clk_48mhz_i,
  input  logic                       rst_ni,
  input  usb_line_pkg::line_cond_t   cond_i,
  input  usb_link_pkg::bus_events_t  events_i,
  input  logic                       pullup_en_i,
  input  logic                       rx_j_det_i,
  input  logic                       sof_detected_i,
  input  logic                       resume_req_i,
  output usb_link_pkg::link_status_t status_o,
  output logic                       link_resume_o
);

  usb_link_pkg::link_state_e state_d, state_q;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    link_resume_o = 1'b0;
    if (!cond_i.powered || !pullup_en_i) begin
      // VBUS gone or pull-up removed, detach from any state
      state_d = usb_link_pkg::link_disconnected;
    end else begin
      unique case (state_q)
        usb_link_pkg::link_disconnected: begin
          state_d = usb_link_pkg::link_powered;
        end
        usb_link_pkg::link_powered: begin
          if (events_i.bus_reset) begin
            state_d = usb_link_pkg::link_active_no_sof;
          end else if (resume_req_i) begin
            // Software restoring a suspend lost across power-down
            state_d = usb_link_pkg::link_resuming;
          end else if (events_i.bus_inactive) begin
            state_d = usb_link_pkg::link_powered_suspended;
          end
        end
        usb_link_pkg::link_powered_suspended: begin
          if (events_i.bus_reset) begin
            state_d = usb_link_pkg::link_active_no_sof;
          end else if (events_i.bus_active) begin
            state_d       = usb_link_pkg::link_powered;
            link_resume_o = 1'b1;
          end
        end
        usb_link_pkg::link_resuming: begin
          // Any J ends resume signaling
          if (rx_j_det_i || events_i.bus_reset) begin
            state_d       = usb_link_pkg::link_active_no_sof;
            link_resume_o = 1'b1;
          end
        end
        usb_link_pkg::link_active_no_sof: begin
          if (events_i.bus_inactive) begin
            state_d = usb_link_pkg::link_suspended;
          end else if (sof_detected_i) begin
            state_d = usb_link_pkg::link_active;
          end
        end
        usb_link_pkg::link_active: begin
          if (events_i.bus_inactive) begin
            state_d = usb_link_pkg::link_suspended;
          end else if (events_i.bus_reset) begin
            state_d = usb_link_pkg::link_active_no_sof;
          end
        end
        usb_link_pkg::link_suspended: begin
          if (events_i.bus_reset) begin
            state_d       = usb_link_pkg::link_active_no_sof;
            link_resume_o = 1'b1;
          end else if (events_i.bus_active) begin
            state_d = usb_link_pkg::link_resuming;
          end
        end
        default: state_d = usb_link_pkg::link_disconnected;
      endcase
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= usb_link_pkg::link_disconnected;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Status decode
  ////////////////////////////////////////////////////////////

  assign status_o.disconnect = (state_q == usb_link_pkg::link_disconnected);
  assign status_o.powered    = cond_i.powered;
  assign status_o.reset      = events_i.in_reset;
  assign status_o.active     = (state_q == usb_link_pkg::link_active) ||
                               (state_q == usb_link_pkg::link_active_no_sof);
  assign status_o.suspend    = (state_q == usb_link_pkg::link_suspended) ||
                               (state_q == usb_link_pkg::link_powered_suspended);
  assign status_o.state      = state_q;

endmodule

// File: hdl/usb_sof_monitor.sv
/*
  SOF monitor. Flags a missed frame each time SofTimeoutUs passes without
  a SOF on an active link; the fourth miss in a row marks the host lost.
*/

`timescale 1ns/1ps

module usb_sof_monitor #(
  parameter int unsigned SofTimeoutUs = 1005
) (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic us_tick_i,
  input  logic link_active_i,
  input  logic in_reset_i,
  input  logic sof_detected_i,
  output logic sof_missed_o,
  output logic host_lost_o
);

  usb_link_pkg::us_count_t frame_timer_q;
  logic [2:0]              miss_cnt_q;
  logic                    clear;

  // Anything that restarts frame tracking
  assign clear = sof_detected_i || !link_active_i || in_reset_i;

  assign sof_missed_o = (frame_timer_q == usb_link_pkg::us_count_t'(SofTimeoutUs));
  // Saturates at four misses
  assign host_lost_o  = miss_cnt_q[2];

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      frame_timer_q <= '0;
      miss_cnt_q    <= '0;
    end else begin
      if (clear || sof_missed_o) begin
        frame_timer_q <= '0;
      end else if (us_tick_i) begin
        frame_timer_q <= frame_timer_q + 1'b1;
      end
      if (clear) begin
        miss_cnt_q <= '0;
      end else if (sof_missed_o && !host_lost_o) begin
        miss_cnt_q <= miss_cnt_q + 3'd1;
      end
    end
  end

endmodule

// File: hdl/usb_link_top.sv
/*
  Top of the link-state tracker. Chains tick generator, line conditioner,
  bus event detector, link FSM and SOF monitor, and hands the timeouts down.
*/

`timescale 1ns/1ps

module usb_link_top #(
  parameter int unsigned ClksPerUs        = 48,
  parameter int unsigned FilterCycles     = 6,
  parameter int unsigned ResetTimeoutUs   = 3,
  parameter int unsigned SuspendTimeoutUs = 3000,
  parameter int unsigned SofTimeoutUs     = 1005
) (
  input  logic                       clk_48mhz_i,
  input  logic                       rst_ni,
  input  usb_line_pkg::line_sample_t line_i,
  input  logic                       pullup_en_i,
  input  logic                       rx_idle_det_i,
  input  logic                       rx_j_det_i,
  input  logic                       sof_detected_i,
  input  logic                       resume_req_i,
  output usb_link_pkg::link_status_t status_o,
  output logic                       link_resume_o,
  output logic                       sof_missed_o,
  output logic                       host_lost_o
);

  logic                      us_tick;
  usb_line_pkg::line_cond_t  cond;
  usb_link_pkg::bus_events_t events;

  usb_us_tick #(
    .ClksPerUs (ClksPerUs)
  ) i_us_tick (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .us_tick_o   (us_tick)
  );

  usb_line_cond #(
    .FilterCycles (FilterCycles)
  ) i_line_cond (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .line_i      (line_i),
    .cond_o      (cond)
  );

  // Registered state fed back to gate idle monitoring
  usb_bus_events #(
    .ResetTimeoutUs   (ResetTimeoutUs),
    .SuspendTimeoutUs (SuspendTimeoutUs)
  ) i_bus_events (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .us_tick_i     (us_tick),
    .cond_i        (cond),
    .rx_idle_det_i (rx_idle_det_i),
    .link_state_i  (status_o.state),
    .events_o      (events)
  );

  usb_link_fsm i_link_fsm (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .cond_i         (cond),
    .events_i       (events),
    .pullup_en_i    (pullup_en_i),
    .rx_j_det_i     (rx_j_det_i),
    .sof_detected_i (sof_detected_i),
    .resume_req_i   (resume_req_i),
    .status_o       (status_o),
    .link_resume_o  (link_resume_o)
  );

  usb_sof_monitor #(
    .SofTimeoutUs (SofTimeoutUs)
  ) i_sof_monitor (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .us_tick_i      (us_tick),
    .link_active_i  (status_o.active),
    .in_reset_i     (events.in_reset),
    .sof_detected_i (sof_detected_i),
    .sof_missed_o   (sof_missed_o),
    .host_lost_o    (host_lost_o)
  );

endmodule

// File: tests/usb_link_sva.sv
/*
  Concurrent checks on the link FSM, bound into every usb_link_fsm
  instance: legal state, one-cycle resume strobe, detach on power loss.
*/

`timescale 1ns/1ps

module usb_link_sva (
  input logic                      clk_48mhz_i,
  input logic                      rst_ni,
  input usb_line_pkg::line_cond_t  cond_i,
  input usb_link_pkg::link_state_e state_i,
  input logic                      link_resume_i
);

  // Only the seven defined encodings may show up
  state_legal_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !$isunknown(state_i) && (state_i <= usb_link_pkg::link_resuming))
    else $error("link state holds an undefined encoding");

  // Resume is a single-cycle strobe
  resume_pulse_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    link_resume_i |=> !link_resume_i)
    else $error("link_resume held high for more than one cycle");

  // Power loss detaches on the following clock
  power_loss_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !cond_i.powered |=> (state_i == usb_link_pkg::link_disconnected))
    else $error("state not disconnected one cycle after power loss");

endmodule

bind usb_link_fsm usb_link_sva i_link_sva (
  .clk_48mhz_i   (clk_48mhz_i),
  .rst_ni        (rst_ni),
  .cond_i        (cond_i),
  .state_i       (state_q),
  .link_resume_i (link_resume_o)
);

// File: tests/usb_link_tb.sv
/*
  Directed testbench for the USB link-state tracker. Runs attach, bus reset,
  frame loss, suspend/resume and powered suspend through usb_link_top with
  short timeouts, then prints a per-test line and a summary.
*/

`timescale 1ns/1ps

module usb_link_tb;

  localparam int ClksPerUs        = 4;
  localparam int FilterCycles     = 6;
  localparam int ResetTimeoutUs   = 3;
  localparam int SuspendTimeoutUs = 40;
  localparam int SofTimeoutUs     = 25;
  localparam int ClkPeriodNs      = 8;
  // Longest single wait is a suspend timeout plus filter delay
  localparam int WaitLimit   = (SuspendTimeoutUs + 10) * ClksPerUs + 4 * FilterCycles;
  localparam int NumWaits    = 24;
  localparam int NumGlitches = 8;
  localparam int WatchdogNs  =
    (NumWaits * WaitLimit + NumGlitches * 3 * FilterCycles + 200) * ClkPeriodNs;

  // Flags that wait_flag can watch
  localparam int FlagReset     = 0;
  localparam int FlagSofMissed = 1;

  logic                       clk = 1'b0;
  logic                       rst_n;
  usb_line_pkg::line_sample_t line;
  logic                       pullup_en;
  logic                       rx_idle_det;
  logic                       rx_j_det;
  logic                       sof_detected;
  logic                       resume_req;
  usb_link_pkg::link_status_t status;
  logic                       link_resume;
  logic                       sof_missed;
  logic                       host_lost;

  int     errors;
  int     checks;
  int     tests_run;
  int     resume_cnt = 0;
  int     se0_cycles = 0;
  integer seed;

  always #(ClkPeriodNs / 2) clk = ~clk;

  // Resume strobes seen so far, sampled on the clock edge
  always @(posedge clk) begin
    if (rst_n && link_resume) begin
      resume_cnt++;
    end
  end

  // Cycles with filtered SE0 high inside the DUT
  always @(posedge clk) begin
    if (rst_n && i_dut.cond.se0) begin
      se0_cycles++;
    end
  end

  usb_link_top #(
    .ClksPerUs        (ClksPerUs),
    .FilterCycles     (FilterCycles),
    .ResetTimeoutUs   (ResetTimeoutUs),
    .SuspendTimeoutUs (SuspendTimeoutUs),
    .SofTimeoutUs     (SofTimeoutUs)
  ) i_dut (
    .clk_48mhz_i    (clk),
    .rst_ni         (rst_n),
    .line_i         (line),
    .pullup_en_i    (pullup_en),
    .rx_idle_det_i  (rx_idle_det),
    .rx_j_det_i     (rx_j_det),
    .sof_detected_i (sof_detected),
    .resume_req_i   (resume_req),
    .status_o       (status),
    .link_resume_o  (link_resume),
    .sof_missed_o   (sof_missed),
    .host_lost_o    (host_lost)
  );

  ////////////////////////////////////////////////////////////
  // Compare and wait helpers
  ////////////////////////////////////////////////////////////

  task automatic check_state(input string name, input usb_link_pkg::link_state_e exp,
                             input usb_link_pkg::link_state_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s expected %s, got %s", $time, name,
               exp.name(), act.name());
    end
  endtask

  task automatic check_status(input string name, input usb_link_pkg::link_status_t exp,
                              input usb_link_pkg::link_status_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // Expected status, field by field
  function automatic usb_link_pkg::link_status_t make_status(
    input logic disc, input logic pwr, input logic rst, input logic act,
    input logic susp, input usb_link_pkg::link_state_e st);
    usb_link_pkg::link_status_t s;
    s.disconnect = disc;
    s.powered    = pwr;
    s.reset      = rst;
    s.active     = act;
    s.suspend    = susp;
    s.state      = st;
    return s;
  endfunction

  function automatic logic flag_value(input int sel);
    case (sel)
      FlagReset: return status.reset;
      default:   return sof_missed;
    endcase
  endfunction

  task automatic wait_state(input usb_link_pkg::link_state_e target);
    int n;
    n = 0;
    @(negedge clk);
    while (status.state !== target && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (status.state !== target) begin
      errors++;
      $display("Timed out after %0d cycles waiting for state %s", WaitLimit, target.name());
    end
  endtask

  task automatic wait_flag(input int sel, input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (flag_value(sel) !== 1'b1 && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (flag_value(sel) !== 1'b1) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %s to rise", WaitLimit, name);
    end
  endtask

  task automatic drive_se0(input logic on);
    @(posedge clk);
    line.dp <= !on;
  endtask

  task automatic report_test(input string name, input int start);
    tests_run++;
    $display("Test %s done, %0d errors", name, errors - start);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic attach_detach();
    int start;
    start = errors;
    @(posedge clk);
    line.sense <= 1'b1;
    pullup_en  <= 1'b1;
    wait_state(usb_link_pkg::link_powered);
    check_status("status_o", make_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                 usb_link_pkg::link_powered), status);
    @(posedge clk);
    pullup_en <= 1'b0;
    wait_state(usb_link_pkg::link_disconnected);
    check_status("status_o", make_status(1'b1, 1'b1, 1'b0, 1'b0, 1'b0,
                 usb_link_pkg::link_disconnected), status);
    report_test("attach", start);
  endtask

  task automatic bus_reset_and_glitches();
    int start;
    int len;
    int base;
    start = errors;
    @(posedge clk);
    pullup_en <= 1'b1;
    wait_state(usb_link_pkg::link_powered);
    // Long SE0 qualifies as a reset
    drive_se0(1'b1);
    wait_flag(FlagReset, "status_o.reset");
    check_status("status_o", make_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0,
                 usb_link_pkg::link_powered), status);
    drive_se0(1'b0);
    wait_state(usb_link_pkg::link_active_no_sof);
    check_status("status_o", make_status(1'b0, 1'b1, 1'b0, 1'b1, 1'b0,
                 usb_link_pkg::link_active_no_sof), status);
    // Short SE0 bursts, EOP-like, never pass the filter
    base = se0_cycles;
    for (int g = 0; g < NumGlitches; g++) begin
      len = 1 + int'($unsigned($random(seed)) % (FilterCycles - 1));
      drive_se0(1'b1);
      repeat (len - 1) @(posedge clk);
      drive_se0(1'b0);
      repeat (FilterCycles + 2) @(posedge clk);
      @(negedge clk);
      check_state("status_o.state", usb_link_pkg::link_active_no_sof, status.state);
      check_bit("status_o.reset", 1'b0, status.reset);
    end
    check_bit("i_dut.cond.se0", 1'b0, se0_cycles != base);
    report_test("bus_reset", start);
  endtask

  task automatic frame_loss();
    int start;
    start = errors;
    @(posedge clk);
    sof_detected <= 1'b1;
    @(posedge clk);
    sof_detected <= 1'b0;
    @(negedge clk);
    check_state("status_o.state", usb_link_pkg::link_active, status.state);
    // Four single-cycle misses in a row mark the host lost
    for (int m = 1; m <= 4; m++) begin
      wait_flag(FlagSofMissed, "sof_missed_o");
      check_bit("host_lost_o", 1'b0, host_lost);
      @(negedge clk);
      check_bit("sof_missed_o", 1'b0, sof_missed);
      check_bit("host_lost_o", m == 4, host_lost);
    end
    @(posedge clk);
    sof_detected <= 1'b1;
    @(posedge clk);
    sof_detected <= 1'b0;
    @(negedge clk);
    check_bit("host_lost_o", 1'b0, host_lost);
    check_bit("sof_missed_o", 1'b0, sof_missed);
    check_state("status_o.state", usb_link_pkg::link_active, status.state);
    report_test("frames", start);
  endtask

  task automatic suspend_and_resume();
    int start;
    int base;
    start = errors;
    @(posedge clk);
    rx_idle_det <= 1'b1;
    wait_state(usb_link_pkg::link_suspended);
    check_status("status_o", make_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b1,
                 usb_link_pkg::link_suspended), status);
    @(posedge clk);
    rx_idle_det <= 1'b0;
    wait_state(usb_link_pkg::link_resuming);
    base = resume_cnt;
    @(posedge clk);
    rx_j_det <= 1'b1;
    @(posedge clk);
    rx_j_det <= 1'b0;
    @(negedge clk);
    check_state("status_o.state", usb_link_pkg::link_active_no_sof, status.state);
    check_bit("link_resume_o single pulse", 1'b1, resume_cnt - base == 1);
    report_test("suspend_resume", start);
  endtask

  task automatic powered_suspend_and_sw_resume();
    int start;
    int base;
    start = errors;
    @(posedge clk);
    pullup_en <= 1'b0;
    wait_state(usb_link_pkg::link_disconnected);
    @(posedge clk);
    pullup_en <= 1'b1;
    wait_state(usb_link_pkg::link_powered);
    @(posedge clk);
    rx_idle_det <= 1'b1;
    wait_state(usb_link_pkg::link_powered_suspended);
    check_status("status_o", make_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b1,
                 usb_link_pkg::link_powered_suspended), status);
    base = resume_cnt;
    @(posedge clk);
    rx_idle_det <= 1'b0;
    wait_state(usb_link_pkg::link_powered);
    check_bit("link_resume_o single pulse", 1'b1, resume_cnt - base == 1);
    // Software asks for resume
    @(posedge clk);
    resume_req <= 1'b1;
    @(posedge clk);
    resume_req <= 1'b0;
    @(negedge clk);
    check_state("status_o.state", usb_link_pkg::link_resuming, status.state);
    report_test("powered_suspend", start);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'hae41;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    rst_n        = 1'b0;
    line         = '{sense: 1'b0, dp: 1'b1, dn: 1'b0, oe: 1'b0};
    pullup_en    = 1'b0;
    rx_idle_det  = 1'b0;
    rx_j_det     = 1'b0;
    sof_detected = 1'b0;
    resume_req   = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_status("status_o", make_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                 usb_link_pkg::link_disconnected), status);
    check_bit("link_resume_o", 1'b0, link_resume);
    check_bit("sof_missed_o", 1'b0, sof_missed);
    check_bit("host_lost_o", 1'b0, host_lost);
    attach_detach();
    bus_reset_and_glitches();
    frame_loss();
    suspend_and_resume();
    powered_suspend_and_sw_resume();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, tests did not complete", WatchdogNs);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: all.f
hdl/usb_line_pkg.sv
hdl/usb_link_pkg.sv
hdl/usb_us_tick.sv
hdl/usb_line_cond.sv
hdl/usb_bus_events.sv
hdl/usb_link_fsm.sv
hdl/usb_sof_monitor.sv
hdl/usb_link_top.sv
tests/usb_link_sva.sv
tests/usb_link_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the link tracker testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module usb_link_tb -f all.f
out=$(./obj_dir/Vusb_link_tb 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Simulation PASSED'; then
  exit 0
fi
exit 1
